/* hw/gat_consts.svh */
/*
 * Size and width constants of the GAT feature transform
 * Base sizes, then the address and index widths derived from them
 */
`ifndef GAT_CONSTS_SVH
`define GAT_CONSTS_SVH

// ====================
// Base sizes
// ====================
`define GAT_DATA_W       8
`define GAT_NUM_NODES    16
`define GAT_FEAT_IN      11
`define GAT_FEAT_OUT     16
`define GAT_H_DEPTH      64
`define GAT_WH_W         20

// ====================
// Derived widths
// ====================
`define GAT_COL_W        ($clog2(`GAT_FEAT_IN))
`define GAT_H_ADDR_W     ($clog2(`GAT_H_DEPTH))
`define GAT_NODE_W       ($clog2(`GAT_NUM_NODES))
`define GAT_ROWLEN_W     ($clog2(`GAT_FEAT_IN + 1))
`define GAT_LANE_W       ($clog2(`GAT_FEAT_OUT))
`define GAT_WGT_ADDR_W   ($clog2(`GAT_FEAT_IN * `GAT_FEAT_OUT))
`define GAT_FEAT_ADDR_W  ($clog2(`GAT_NUM_NODES * `GAT_FEAT_OUT))

`endif

/* hw/gat_pkg.sv */
/*
 * Shared data types of the GAT feature transform
 * H entry, addresses, weights and result rows
 */
`include "gat_consts.svh"

package gat_pkg;

  // One nonzero of H
  typedef struct packed {
    logic [`GAT_DATA_W-1:0] val;
    logic [`GAT_COL_W-1:0]  col;
  } h_entry_t;

  typedef logic [`GAT_H_ADDR_W-1:0]    h_addr_t;
  typedef logic [`GAT_NODE_W-1:0]      node_t;
  typedef logic [`GAT_ROWLEN_W-1:0]    row_len_t;
  typedef logic [`GAT_DATA_W-1:0]      wgt_t;
  typedef wgt_t [`GAT_FEAT_OUT-1:0]    wgt_row_t;

  // Result element and one full WH row
  typedef logic [`GAT_WH_W-1:0]        wh_t;
  typedef wh_t [`GAT_FEAT_OUT-1:0]     wh_row_t;
  typedef logic [`GAT_FEAT_ADDR_W-1:0] feat_addr_t;

endpackage

/* hw/graph_mem_if.sv */
/*
 * Read channel between the input memories and the SpMM engine
 * Addresses from the engine, registered data back from the memories
 */
`timescale 1ns/1ps
`include "gat_consts.svh"

interface graph_mem_if import gat_pkg::*; ();

  // Read addresses
  h_addr_t               h_addr;
  node_t                 node_addr;
  logic [`GAT_COL_W-1:0] wgt_row_addr;

  // Read data one clock after the address
  h_entry_t              h_data;
  row_len_t              row_len;
  wgt_row_t              wgt_row;

  modport mem (
    input  h_addr, node_addr, wgt_row_addr,
    output h_data, row_len, wgt_row
  );

  modport engine (
    output h_addr, node_addr, wgt_row_addr,
    input  h_data, row_len, wgt_row
  );

endinterface

/* hw/load_memory.sv */
/*
 * Input memories of the feature transform
 * H nonzeros, per-row lengths and the W matrix as row words
 * Host write ports and registered engine reads
 */
`timescale 1ns/1ps
`include "gat_consts.svh"

module load_memory import gat_pkg::*; (
  input  logic                       clk,

  input  h_entry_t                   h_data_bram_din,
  input  logic                       h_data_bram_ena,
  input  logic                       h_data_bram_wea,
  input  h_addr_t                    h_data_bram_addra,

  input  row_len_t                   h_node_info_bram_din,
  input  logic                       h_node_info_bram_ena,
  input  logic                       h_node_info_bram_wea,
  input  node_t                      h_node_info_bram_addra,

  input  wgt_t                       wgt_bram_din,
  input  logic                       wgt_bram_ena,
  input  logic                       wgt_bram_wea,
  input  logic [`GAT_WGT_ADDR_W-1:0] wgt_bram_addra,

  graph_mem_if.mem                   mem
);

  h_entry_t h_mem   [`GAT_H_DEPTH];
  row_len_t row_mem [`GAT_NUM_NODES];
  wgt_row_t wgt_mem [`GAT_FEAT_IN];

  logic [`GAT_WGT_ADDR_W-`GAT_LANE_W-1:0] wr_row;
  logic [`GAT_LANE_W-1:0]                 wr_lane;

  // Weight address is row * 16 + lane
  assign wr_row  = wgt_bram_addra[`GAT_WGT_ADDR_W-1:`GAT_LANE_W];
  assign wr_lane = wgt_bram_addra[`GAT_LANE_W-1:0];

  // ====================
  // Host writes
  // ====================
  always_ff @(posedge clk) begin
    if (h_data_bram_ena && h_data_bram_wea)
      h_mem[h_data_bram_addra] <= h_data_bram_din;
    if (h_node_info_bram_ena && h_node_info_bram_wea)
      row_mem[h_node_info_bram_addra] <= h_node_info_bram_din;
    if (wgt_bram_ena && wgt_bram_wea && (wr_row < `GAT_FEAT_IN))
      wgt_mem[wr_row][wr_lane] <= wgt_bram_din;
  end

  // Engine reads
  always_ff @(posedge clk) begin
    mem.h_data  <= h_mem[mem.h_addr];
    mem.row_len <= row_mem[mem.node_addr];
    mem.wgt_row <= wgt_mem[mem.wgt_row_addr];
  end

endmodule

/* hw/spmm_engine.sv */
/*
 * Sparse H times dense W engine
 * Walks the rows in CSR order, 16-lane multiply-accumulate,
 * writes one WH row per node and flags the end of the run
 */
`timescale 1ns/1ps
`include "gat_consts.svh"

module spmm_engine import gat_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,

  input  logic        h_data_bram_load_done,
  input  logic        h_node_info_bram_load_done,
  input  logic        wgt_bram_load_done,

  graph_mem_if.engine eng,

  output logic        wh_wr_en,
  output node_t       wh_node,
  output wh_row_t     wh_row,
  output logic        gat_ready
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_LEN,
    S_ENT,
    S_WGT,
    S_ACC,
    S_WRITE,
    S_DONE
  } state_t;

  state_t   state;
  node_t    node;
  h_addr_t  h_ptr;
  row_len_t remain;
  logic     len_ph;
  logic     prod_vld;
  logic     all_loaded;

  logic [`GAT_DATA_W-1:0]   val_q;
  logic [2*`GAT_DATA_W-1:0] prod [`GAT_FEAT_OUT];
  wh_row_t                  acc;

  assign all_loaded = h_data_bram_load_done & h_node_info_bram_load_done &
                      wgt_bram_load_done;

  // Read addresses from the counters and the fetched column
  assign eng.node_addr    = node;
  assign eng.h_addr       = h_ptr;
  assign eng.wgt_row_addr = eng.h_data.col;

  // ====================
  // Control FSM
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= S_IDLE;
      node     <= '0;
      h_ptr    <= '0;
      remain   <= '0;
      len_ph   <= 1'b0;
      prod_vld <= 1'b0;
    end else begin
      prod_vld <= (state == S_WGT);
      case (state)
        S_IDLE: begin
          if (all_loaded)
            state <= S_LEN;
        end
        S_LEN: begin
          // Second clock has the row length
          len_ph <= ~len_ph;
          if (len_ph) begin
            remain <= eng.row_len;
            state  <= (eng.row_len == '0) ? S_WRITE : S_ENT;
          end
        end
        S_ENT: begin
          h_ptr  <= h_ptr + 1'b1;
          remain <= remain - 1'b1;
          state  <= S_WGT;
        end
        S_WGT: begin
          state <= (remain == '0) ? S_ACC : S_ENT;
        end
        S_ACC: begin
          state <= S_WRITE;
        end
        S_WRITE: begin
          node  <= node + 1'b1;
          state <= (node == node_t'(`GAT_NUM_NODES - 1)) ? S_DONE : S_LEN;
        end
        S_DONE: begin
          state <= S_DONE;
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // ====================
  // Lanes
  // ====================
  // Products land one clock after the weight row and are summed on the next
  always_ff @(posedge clk) begin
    if (state == S_ENT)
      val_q <= eng.h_data.val;
    for (int i = 0; i < `GAT_FEAT_OUT; i++) begin
      prod[i] <= val_q * eng.wgt_row[i];
      if (state == S_LEN)
        acc[i] <= '0;
      else if (prod_vld)
        acc[i] <= acc[i] + wh_t'(prod[i]);
    end
  end

  assign wh_wr_en  = (state == S_WRITE);
  assign wh_node   = node;
  assign wh_row    = acc;
  assign gat_ready = (state == S_DONE);

endmodule

/* hw/feature_memory.sv */
/*
 * Result memory of the WH rows
 * One row write per node, registered element read for the host
 */
`timescale 1ns/1ps
`include "gat_consts.svh"

module feature_memory import gat_pkg::*; (
  input  logic       clk,

  input  logic       wh_wr_en,
  input  node_t      wh_node,
  input  wh_row_t    wh_row,

  input  feat_addr_t feat_bram_addrb,
  output wh_t        feat_bram_dout
);

  wh_row_t fmem [`GAT_NUM_NODES];

  node_t                  rd_node;
  logic [`GAT_LANE_W-1:0] rd_lane;

  // Element address is node * 16 + lane
  assign rd_node = feat_bram_addrb[`GAT_FEAT_ADDR_W-1:`GAT_LANE_W];
  assign rd_lane = feat_bram_addrb[`GAT_LANE_W-1:0];

  // Whole row in one clock
  always_ff @(posedge clk) begin
    if (wh_wr_en)
      fmem[wh_node] <= wh_row;
  end

  always_ff @(posedge clk) begin
    feat_bram_dout <= fmem[rd_node][rd_lane];
  end

endmodule

/* hw/gat_top.sv */
/*
 * Top level of the GAT feature transform
 * Input memories, SpMM engine and result memory on plain ports
 */
`timescale 1ns/1ps
`include "gat_consts.svh"

module gat_top import gat_pkg::*; (
  input  logic                       clk,
  input  logic                       rst_n,

  input  h_entry_t                   h_data_bram_din,
  input  logic                       h_data_bram_ena,
  input  logic                       h_data_bram_wea,
  input  h_addr_t                    h_data_bram_addra,

  input  row_len_t                   h_node_info_bram_din,
  input  logic                       h_node_info_bram_ena,
  input  logic                       h_node_info_bram_wea,
  input  node_t                      h_node_info_bram_addra,

  input  wgt_t                       wgt_bram_din,
  input  logic                       wgt_bram_ena,
  input  logic                       wgt_bram_wea,
  input  logic [`GAT_WGT_ADDR_W-1:0] wgt_bram_addra,

  input  logic                       h_data_bram_load_done,
  input  logic                       h_node_info_bram_load_done,
  input  logic                       wgt_bram_load_done,

  input  feat_addr_t                 feat_bram_addrb,
  output wh_t                        feat_bram_dout,
  output logic                       gat_ready
);

  // Result write group
  logic    wh_wr_en;
  node_t   wh_node;
  wh_row_t wh_row;

  graph_mem_if u_gmem ();

  load_memory u_load_memory (
    .clk                    (clk),
    .h_data_bram_din        (h_data_bram_din),
    .h_data_bram_ena        (h_data_bram_ena),
    .h_data_bram_wea        (h_data_bram_wea),
    .h_data_bram_addra      (h_data_bram_addra),
    .h_node_info_bram_din   (h_node_info_bram_din),
    .h_node_info_bram_ena   (h_node_info_bram_ena),
    .h_node_info_bram_wea   (h_node_info_bram_wea),
    .h_node_info_bram_addra (h_node_info_bram_addra),
    .wgt_bram_din           (wgt_bram_din),
    .wgt_bram_ena           (wgt_bram_ena),
    .wgt_bram_wea           (wgt_bram_wea),
    .wgt_bram_addra         (wgt_bram_addra),
    .mem                    (u_gmem.mem)
  );

  spmm_engine u_spmm_engine (
    .clk                        (clk),
    .rst_n                      (rst_n),
    .h_data_bram_load_done      (h_data_bram_load_done),
    .h_node_info_bram_load_done (h_node_info_bram_load_done),
    .wgt_bram_load_done         (wgt_bram_load_done),
    .eng                        (u_gmem.engine),
    .wh_wr_en                   (wh_wr_en),
    .wh_node                    (wh_node),
    .wh_row                     (wh_row),
    .gat_ready                  (gat_ready)
  );

  feature_memory u_feature_memory (
    .clk             (clk),
    .wh_wr_en        (wh_wr_en),
    .wh_node         (wh_node),
    .wh_row          (wh_row),
    .feat_bram_addrb (feat_bram_addrb),
    .feat_bram_dout  (feat_bram_dout)
  );

endmodule

/* test/gat_props.sv */
/*
 * Concurrent assertions on the top-level control signals
 * Bound into gat_top
 */
`timescale 1ns/1ps

module gat_props (
  input logic clk,
  input logic rst_n,
  input logic h_data_bram_load_done,
  input logic h_node_info_bram_load_done,
  input logic wgt_bram_load_done,
  input logic gat_ready
);

  // No result before all three loads are in
  a_ready_needs_loads: assert property (@(posedge clk) disable iff (!rst_n)
    (!h_data_bram_load_done || !h_node_info_bram_load_done || !wgt_bram_load_done)
      |-> !gat_ready)
    else $error("gat_ready high while a load_done input is low");

  a_ready_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    gat_ready |=> gat_ready)
    else $error("gat_ready fell after it was set");

  a_ready_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(gat_ready))
    else $error("gat_ready is unknown after reset");

endmodule

bind gat_top gat_props u_gat_props (
  .clk                        (clk),
  .rst_n                      (rst_n),
  .h_data_bram_load_done      (h_data_bram_load_done),
  .h_node_info_bram_load_done (h_node_info_bram_load_done),
  .wgt_bram_load_done         (wgt_bram_load_done),
  .gat_ready                  (gat_ready)
);

/* test/gat_tb.sv */
/*
 * Testbench of the GAT feature transform
 * Random sparse graph, host loading, integer WH model,
 * compare tasks, result readback, watchdog and summary
 */
`timescale 1ns/1ps
`include "gat_consts.svh"

module gat_tb import gat_pkg::*; ();

  localparam int CLK_PERIOD  = 20;
  localparam int WDOG_CYCLES = 8 + 16 * 2 + 64 * 4 + 16 * 4 + 16 * 16 * 2 + 200;

  typedef logic [`GAT_COL_W-1:0]      col_t;
  typedef logic [`GAT_DATA_W-1:0]     val_t;
  typedef logic [`GAT_WGT_ADDR_W-1:0] wgt_addr_t;

  logic       clk;
  logic       rst_n;
  h_entry_t   h_data_bram_din;
  logic       h_data_bram_ena;
  logic       h_data_bram_wea;
  h_addr_t    h_data_bram_addra;
  row_len_t   h_node_info_bram_din;
  logic       h_node_info_bram_ena;
  logic       h_node_info_bram_wea;
  node_t      h_node_info_bram_addra;
  wgt_t       wgt_bram_din;
  logic       wgt_bram_ena;
  logic       wgt_bram_wea;
  wgt_addr_t  wgt_bram_addra;
  logic       h_data_bram_load_done;
  logic       h_node_info_bram_load_done;
  logic       wgt_bram_load_done;
  feat_addr_t feat_bram_addrb;
  wh_t        feat_bram_dout;
  logic       gat_ready;

  // Reference graph and model
  h_entry_t h_m       [`GAT_H_DEPTH];
  row_len_t row_len_m [`GAT_NUM_NODES];
  wgt_t     wgt_m     [`GAT_FEAT_IN][`GAT_FEAT_OUT];
  int       wh_exp    [`GAT_NUM_NODES][`GAT_FEAT_OUT];
  wh_t      got       [`GAT_NUM_NODES * `GAT_FEAT_OUT];
  int       n_h;
  int       seed;
  int       pass_cnt;
  int       fail_cnt;
  int       errs;

  gat_top UUT (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ====================
  // Compare tasks
  // ====================
  task automatic check_wh(input wh_t actual, input wh_t expected, input feat_addr_t addr);
    if (actual !== expected) begin
      $display("[ERROR] %0t feat_bram_dout addr %0d: expected %0d, actual %0d",
               $time, addr, expected, actual);
      fail_cnt++;
    end else begin
      pass_cnt++;
    end
  endtask

  task automatic check_ready(input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t gat_ready: expected %b, actual %b", $time, expected, actual);
      fail_cnt++;
    end else begin
      pass_cnt++;
    end
  endtask

  task automatic test_done(input string name, input int errs_before);
    $display("Test %s: done, %0d errors", name, fail_cnt - errs_before);
  endtask

  // ====================
  // Graph and model
  // ====================
  task automatic build_graph();
    int                      nnz;
    col_t                    col;
    logic [`GAT_FEAT_IN-1:0] used;
    logic [`GAT_FEAT_IN-1:0] sat_cols;
    n_h = 0;
    sat_cols = '0;
    for (int n = 0; n < `GAT_NUM_NODES; n++) begin
      used = '0;
      if (n == 0 || n == 5)
        nnz = 0;
      else if (n == 3)
        nnz = 4;
      else
        nnz = int'($unsigned($random(seed)) % 5);
      if (n_h + nnz > `GAT_H_DEPTH)
        nnz = `GAT_H_DEPTH - n_h;
      row_len_m[n] = row_len_t'(nnz);
      for (int k = 0; k < nnz; k++) begin
        do
          col = col_t'($unsigned($random(seed)) % `GAT_FEAT_IN);
        while (used[col]);
        used[col] = 1'b1;
        h_m[n_h].col = col;
        h_m[n_h].val = (n == 3) ? val_t'(255) : val_t'($random(seed));
        if (n == 3)
          sat_cols[col] = 1'b1;
        n_h++;
      end
    end
    // Row 3 columns get all-255 weight rows
    for (int r = 0; r < `GAT_FEAT_IN; r++)
      for (int c = 0; c < `GAT_FEAT_OUT; c++)
        wgt_m[r][c] = sat_cols[r] ? wgt_t'(255) : wgt_t'($random(seed));
  endtask

  task automatic compute_model();
    int p;
    p = 0;
    for (int n = 0; n < `GAT_NUM_NODES; n++) begin
      for (int l = 0; l < `GAT_FEAT_OUT; l++)
        wh_exp[n][l] = 0;
      for (int k = 0; k < int'(row_len_m[n]); k++) begin
        for (int l = 0; l < `GAT_FEAT_OUT; l++)
          wh_exp[n][l] += int'(h_m[p].val) * int'(wgt_m[h_m[p].col][l]);
        p++;
      end
    end
  endtask

  // ====================
  // Host drivers
  // ====================
  task automatic write_h(input int idx);
    @(negedge clk);
    check_ready(gat_ready, 1'b0);
    h_data_bram_din   = h_m[idx];
    h_data_bram_addra = h_addr_t'(idx);
    h_data_bram_ena   = 1'b1;
    h_data_bram_wea   = 1'b1;
  endtask

  task automatic write_row(input int n);
    @(negedge clk);
    check_ready(gat_ready, 1'b0);
    h_node_info_bram_din   = row_len_m[n];
    h_node_info_bram_addra = node_t'(n);
    h_node_info_bram_ena   = 1'b1;
    h_node_info_bram_wea   = 1'b1;
  endtask

  task automatic write_wgt(input int r, input int c);
    @(negedge clk);
    check_ready(gat_ready, 1'b0);
    wgt_bram_din   = wgt_m[r][c];
    wgt_bram_addra = wgt_addr_t'(r * `GAT_FEAT_OUT + c);
    wgt_bram_ena   = 1'b1;
    wgt_bram_wea   = 1'b1;
  endtask

  task automatic end_writes();
    @(negedge clk);
    h_data_bram_ena      = 1'b0;
    h_data_bram_wea      = 1'b0;
    h_node_info_bram_ena = 1'b0;
    h_node_info_bram_wea = 1'b0;
    wgt_bram_ena         = 1'b0;
    wgt_bram_wea         = 1'b0;
  endtask

  task automatic hold_and_check(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      check_ready(gat_ready, 1'b0);
    end
  endtask

  // Watchdog
  initial begin
    #(WDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the run did not finish", WDOG_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    int cycles;
    clk = 1'b0;
    rst_n = 1'b0;
    h_data_bram_din = '0;
    h_data_bram_ena = 1'b0;
    h_data_bram_wea = 1'b0;
    h_data_bram_addra = '0;
    h_node_info_bram_din = '0;
    h_node_info_bram_ena = 1'b0;
    h_node_info_bram_wea = 1'b0;
    h_node_info_bram_addra = '0;
    wgt_bram_din = '0;
    wgt_bram_ena = 1'b0;
    wgt_bram_wea = 1'b0;
    wgt_bram_addra = '0;
    h_data_bram_load_done = 1'b0;
    h_node_info_bram_load_done = 1'b0;
    wgt_bram_load_done = 1'b0;
    feat_bram_addrb = '0;
    pass_cnt = 0;
    fail_cnt = 0;
    seed = 32'h9c60_0a99;
    build_graph();
    compute_model();
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    // Loads with the done levels raised one at a time
    errs = fail_cnt;
    for (int i = 0; i < n_h; i++)
      write_h(i);
    end_writes();
    h_data_bram_load_done = 1'b1;
    hold_and_check(4);
    for (int n = 0; n < `GAT_NUM_NODES; n++)
      write_row(n);
    end_writes();
    h_node_info_bram_load_done = 1'b1;
    hold_and_check(4);
    for (int r = 0; r < `GAT_FEAT_IN; r++)
      for (int c = 0; c < `GAT_FEAT_OUT; c++)
        write_wgt(r, c);
    end_writes();
    hold_and_check(4);
    test_done("1 loading keeps gat_ready low", errs);

    errs = fail_cnt;
    wgt_bram_load_done = 1'b1;
    cycles = 0;
    while (gat_ready !== 1'b1 && cycles < 400) begin
      @(negedge clk);
      cycles++;
    end
    if (gat_ready !== 1'b1) begin
      $display("gat_ready did not rise within 400 cycles after the loads were done");
      fail_cnt++;
    end else begin
      pass_cnt++;
    end
    test_done("2 run completes", errs);

    // Pipelined readback at one address per clock
    errs = fail_cnt;
    @(negedge clk);
    feat_bram_addrb = '0;
    for (int a = 1; a <= `GAT_NUM_NODES * `GAT_FEAT_OUT; a++) begin
      @(negedge clk);
      check_wh(feat_bram_dout, wh_t'(wh_exp[(a - 1) / 16][(a - 1) % 16]),
               feat_addr_t'(a - 1));
      got[a - 1] = feat_bram_dout;
      feat_bram_addrb = feat_addr_t'(a);
    end
    check_ready(gat_ready, 1'b1);
    test_done("3 WH readback", errs);

    errs = fail_cnt;
    for (int l = 0; l < `GAT_FEAT_OUT; l++) begin
      check_wh(got[l], wh_t'(0), feat_addr_t'(l));
      check_wh(got[5 * 16 + l], wh_t'(0), feat_addr_t'(5 * 16 + l));
    end
    test_done("4 empty rows 0 and 5", errs);

    errs = fail_cnt;
    for (int l = 0; l < `GAT_FEAT_OUT; l++)
      check_wh(got[3 * 16 + l], wh_t'(4 * 255 * 255), feat_addr_t'(3 * 16 + l));
    test_done("5 saturated row 3", errs);

    $display("Summary: %0d passed, %0d errors", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+hw
hw/gat_pkg.sv
hw/graph_mem_if.sv
hw/load_memory.sv
hw/spmm_engine.sv
hw/feature_memory.sv
hw/gat_top.sv
test/gat_props.sv
test/gat_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Verilator build and run of the GAT feature transform testbench
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module gat_tb -o gat_sim

./obj_dir/gat_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "^ALL CHECKS PASSED$" "$LOG"; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1
